/* Makefile */
# Verilator build and run of the PPU testbench

VERILATOR ?= verilator
TOP       ?= tb_ppu_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
common/ppu_pkg.sv
source/axil_bridge.sv
source/video_mem.sv
ppu/lcd_timing.sv
ppu/ppu_regs.sv
ppu/ppu_irq.sv
source/ppu_top.sv
test/tb_ppu_top.sv

/* test/tb_ppu_top.sv */
module tb_ppu_top;

  localparam int          CLK_PERIOD   = 4;
  localparam int          RESET_CYCLES = 4;
  localparam logic [31:0] SEED         = 32'hb841_ca4a;

  // Frame timing, one dot per clock
  localparam int LINE_CYCLES     = 456;
  localparam int FRAME_LINES     = 154;
  localparam int VISIBLE_LINES   = 144;
  localparam int MODE0_DOT       = 80 + 172;
  localparam int FRAME_CYCLES    = LINE_CYCLES * FRAME_LINES;
  localparam int WATCHDOG_CYCLES = 5 * FRAME_CYCLES + 20000;

  // CPU address map
  localparam int VRAM_BASE = 'h8000;
  localparam int VRAM_SIZE = 8192;
  localparam int OAM_BASE  = 'hFE00;
  localparam int OAM_SIZE  = 160;
  localparam int REG_LCDC  = 'hFF40;
  localparam int REG_STAT  = 'hFF41;
  localparam int REG_SCY   = 'hFF42;
  localparam int REG_SCX   = 'hFF43;
  localparam int REG_LY    = 'hFF44;
  localparam int REG_LYC   = 'hFF45;
  localparam int DMA_REG   = 'hFF46;
  localparam int REG_BGP   = 'hFF47;
  localparam int REG_WY    = 'hFF4A;
  localparam int REG_WX    = 'hFF4B;
  localparam int UNMAPPED  = 'hC000;
  // Random addresses per memory
  localparam int MEM_WRITES = 48;

  logic        clk;
  logic        reset;
  logic        awvalid;
  logic [15:0] awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wready;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        bready;
  logic        arvalid;
  logic [15:0] araddr;
  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rready;
  logic        stat_req;
  logic        vblank_req;

  int checks       = 0;
  int value_errors = 0;
  int other_errors = 0;

  // Pulse bookkeeping
  int cycle        = 0;
  int vblank_count = 0;
  int vblank_cycle = 0;
  int stat_count   = 0;
  bit collect_stat = 1'b0;
  int stat_cycles[$];

  // Byte model of both memories, keyed by CPU address
  int mem_model[int];

  ppu_top #(.VRAM_DEPTH(VRAM_SIZE), .OAM_DEPTH(OAM_SIZE)) ppu_top_i (
    .clk, .reset,
    .awvalid, .awaddr, .awready, .wvalid, .wdata, .wstrb, .wready,
    .bvalid, .bresp, .bready,
    .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp, .rready,
    .stat_req, .vblank_req
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Cycle count and pulse capture
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (vblank_req) begin
      vblank_count = vblank_count + 1;
      vblank_cycle = cycle;
    end
    if (stat_req) begin
      stat_count = stat_count + 1;
      if (collect_stat) begin
        stat_cycles.push_back(cycle);
      end
    end
  end

  // ==========================================================================
  // Bus and pulse properties
  // ==========================================================================

  // Ready pulses come as a pair
  assert property (@(posedge clk) disable iff (reset) awready == wready)
    else begin
      value_errors++;
      $display("FAILED at time %0t: wready expected %0b, got %0b", $time,
               $sampled(awready), $sampled(wready));
    end

  // Responses hold until taken
  assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
    else begin
      value_errors++;
      $display("FAILED at time %0t: bvalid expected 1, got 0", $time);
    end

  assert property (@(posedge clk) disable iff (reset) rvalid && !rready |=> rvalid)
    else begin
      value_errors++;
      $display("FAILED at time %0t: rvalid expected 1, got 0", $time);
    end

  // VBlank request is one cycle wide
  assert property (@(posedge clk) disable iff (reset) vblank_req |=> !vblank_req)
    else begin
      value_errors++;
      $display("FAILED at time %0t: vblank_req expected 0, got 1", $time);
    end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic expect_equal(input string name, input int exp, input int got);
    checks++;
    assert (got == exp) else begin
      value_errors++;
      $display("FAILED at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    end
  endtask

  task automatic expect_range(input string name, input int lo, input int hi, input int got);
    checks++;
    assert (got >= lo && got <= hi) else begin
      value_errors++;
      $display("FAILED at time %0t: %s expected %0d to %0d, got %0d", $time, name, lo, hi,
               got);
    end
  endtask

  // Called and returns on a falling edge
  task automatic axil_write(input int addr, input int data);
    awvalid = 1'b1;
    awaddr  = 16'(addr);
    wvalid  = 1'b1;
    // Upper lanes carry junk
    wdata   = {24'($urandom), 8'(data)};
    wstrb   = 4'b0001;
    while (!(awready && wready)) @(negedge clk);
    // Accepted on the rising edge in between
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    expect_equal("bresp", 0, int'(bresp));
    // Response left waiting for a few cycles
    repeat ($urandom % 3) @(negedge clk);
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input int addr, output int data);
    arvalid = 1'b1;
    araddr  = 16'(addr);
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    expect_equal("rresp", 0, int'(rresp));
    // Byte is zero-extended
    expect_equal("rdata[31:8]", 0, int'(rdata[31:8]));
    data   = int'(rdata[7:0]);
    // Read data left waiting for a few cycles
    repeat ($urandom % 3) @(negedge clk);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic wait_vblank();
    int start_count;
    start_count = vblank_count;
    while (vblank_count == start_count) @(negedge clk);
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial begin
    int rw_regs[6];
    int addrs[$];
    int lcdc_val;
    int lyc_val;
    int val;
    int got;
    int stat;
    int ly_a;
    int ly_b;
    int start;
    int samples;
    int vb_start;
    int n_vb;
    int n_st;
    int pulses;

    awvalid = 1'b0;
    awaddr  = 16'h0;
    wvalid  = 1'b0;
    wdata   = 32'h0;
    wstrb   = 4'h0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = 16'h0;
    rready  = 1'b0;
    reset   = 1'b1;
    void'($urandom(SEED));
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // Quiet outputs out of reset
    expect_equal("awready", 0, int'(awready));
    expect_equal("wready", 0, int'(wready));
    expect_equal("arready", 0, int'(arready));
    expect_equal("bvalid", 0, int'(bvalid));
    expect_equal("rvalid", 0, int'(rvalid));
    expect_equal("stat_req", 0, int'(stat_req));
    expect_equal("vblank_req", 0, int'(vblank_req));

    // Registers with the LCD off
    lcdc_val = $urandom & 'h7F;
    axil_write(REG_LCDC, lcdc_val);
    axil_read(REG_LCDC, got);
    expect_equal("LCDC", lcdc_val, got);
    rw_regs = '{REG_SCY, REG_SCX, REG_LYC, REG_BGP, REG_WY, REG_WX};
    lyc_val = 0;
    foreach (rw_regs[i]) begin
      val = $urandom & 'hFF;
      axil_write(rw_regs[i], val);
      axil_read(rw_regs[i], got);
      expect_equal($sformatf("register 0x%04h", rw_regs[i]), val, got);
      if (rw_regs[i] == REG_LYC) begin
        lyc_val = val;
      end
    end
    // Bit 7 set, enables, coincidence, mode 2 while off
    val = $urandom & 'hFF;
    axil_write(REG_STAT, val);
    axil_read(REG_STAT, got);
    expect_equal("STAT", 'h80 | (val & 'h78) | (lyc_val == 0 ? 4 : 0) | 2, got);
    axil_write(REG_LY, $urandom & 'hFF);
    axil_read(REG_LY, got);
    expect_equal("LY", 0, got);
    axil_read(UNMAPPED, got);
    expect_equal("unmapped read", 'hFF, got);
    axil_read(DMA_REG, got);
    expect_equal("DMA register read", 'hFF, got);

    // Memory round trip, both ends of each memory first
    addrs = '{VRAM_BASE, VRAM_BASE + VRAM_SIZE - 1, OAM_BASE, OAM_BASE + OAM_SIZE - 1};
    for (int i = 0; i < MEM_WRITES; i++) begin
      addrs.push_back(VRAM_BASE + int'($urandom % VRAM_SIZE));
      addrs.push_back(OAM_BASE + int'($urandom % OAM_SIZE));
    end
    foreach (addrs[i]) begin
      val = $urandom & 'hFF;
      axil_write(addrs[i], val);
      mem_model[addrs[i]] = val;
    end
    foreach (addrs[i]) begin
      axil_read(addrs[i], got);
      expect_equal($sformatf("memory 0x%04h", addrs[i]), mem_model[addrs[i]], got);
    end

    // ========================================================================
    // LCD running
    // ========================================================================

    lyc_val = $urandom % FRAME_LINES;
    axil_write(REG_LYC, lyc_val);
    axil_write(REG_LCDC, 'h80 | lcdc_val);
    do axil_read(REG_STAT, stat); while ((stat & 3) != 3);
    // VRAM locked, OAM open
    axil_read(VRAM_BASE, got);
    expect_equal("VRAM read in mode 3", 'hFF, got);
    axil_write(VRAM_BASE, mem_model[VRAM_BASE] ^ 'hFF);
    val = $urandom & 'hFF;
    axil_write(OAM_BASE + 1, val);
    mem_model[OAM_BASE + 1] = val;
    axil_read(OAM_BASE + 1, got);
    expect_equal("OAM read in mode 3", val, got);
    axil_read(REG_STAT, stat);
    expect_equal("STAT mode after mode-3 accesses", 3, stat & 3);
    do axil_read(REG_STAT, stat); while ((stat & 3) != 0);
    axil_read(VRAM_BASE, got);
    expect_equal("VRAM after blocked write", mem_model[VRAM_BASE], got);

    // One frame of LY and STAT samples, kept only if LY held still
    start   = cycle;
    samples = 0;
    while (cycle - start < FRAME_CYCLES) begin
      axil_read(REG_LY, ly_a);
      axil_read(REG_STAT, stat);
      axil_read(REG_LY, ly_b);
      expect_range("LY", 0, FRAME_LINES - 1, ly_a);
      expect_range("LY", 0, FRAME_LINES - 1, ly_b);
      if (ly_a == ly_b) begin
        samples++;
        expect_equal("STAT mode 1 flag", int'(ly_a >= VISIBLE_LINES), int'((stat & 3) == 1));
        expect_equal("STAT coincidence", int'(ly_a == lyc_val), (stat >> 2) & 1);
      end
    end
    if (samples == 0) begin
      other_errors++;
      $display("No stable LY sample was taken during the running frame");
    end

    // VBlank period, mode-0 STAT enable armed for the next frame
    axil_write(REG_STAT, 'h08);
    wait_vblank();
    axil_read(REG_LY, got);
    expect_range("LY after vblank_req", VISIBLE_LINES, FRAME_LINES - 1, got);
    vb_start = vblank_cycle;
    wait_vblank();
    expect_equal("vblank_req period", FRAME_CYCLES, vblank_cycle - vb_start);

    // HBlank STAT pulses over one frame
    vb_start = vblank_cycle;
    stat_cycles.delete();
    collect_stat = 1'b1;
    wait_vblank();
    collect_stat = 1'b0;
    expect_equal("stat_req pulses per frame", VISIBLE_LINES, stat_cycles.size());
    if (stat_cycles.size() > 0) begin
      // Ten VBlank lines pass before line 0 reaches HBlank
      expect_equal("first stat_req after vblank_req",
                   (FRAME_LINES - VISIBLE_LINES) * LINE_CYCLES + MODE0_DOT,
                   stat_cycles[0] - vb_start);
      expect_equal("last stat_req before vblank_req", LINE_CYCLES - MODE0_DOT,
                   vblank_cycle - stat_cycles[$]);
      for (int i = 1; i < stat_cycles.size(); i++) begin
        expect_equal("stat_req period", LINE_CYCLES, stat_cycles[i] - stat_cycles[i - 1]);
      end
    end

    // LYC STAT pulse, one per frame
    lyc_val = $urandom % FRAME_LINES;
    n_vb    = vblank_count;
    n_st    = stat_count;
    pulses  = 0;
    axil_write(REG_STAT, 'h40);
    axil_write(REG_LYC, lyc_val);
    while (vblank_count == n_vb) begin
      @(negedge clk);
      if (stat_count != n_st) begin
        pulses = pulses + stat_count - n_st;
        n_st   = stat_count;
        axil_read(REG_LY, got);
        expect_equal("LY after LYC stat_req", lyc_val, got);
      end
    end
    expect_equal("LYC stat_req pulses per frame", 1, pulses);

    $display("Checks: %0d, value errors: %0d, other errors: %0d", checks, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog sized for five frames plus the LCD-off tests
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    other_errors++;
    $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Checks: %0d, value errors: %0d, other errors: %0d", checks, value_errors,
             other_errors);
    $display("Verification failed");
    $finish;
  end

endmodule

/* source/ppu_top.sv */
module ppu_top
  import ppu_pkg::*;
#(
  parameter int VRAM_DEPTH = 8192,
  parameter int OAM_DEPTH  = 160
) (
  input  logic        clk,
  input  logic        reset,
  // AXI4-Lite slave
  input  logic        awvalid,
  input  logic [15:0] awaddr,
  output logic        awready,
  input  logic        wvalid,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic        wready,
  output logic        bvalid,
  output logic [1:0]  bresp,
  input  logic        bready,
  input  logic        arvalid,
  input  logic [15:0] araddr,
  output logic        arready,
  output logic        rvalid,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  input  logic        rready,
  // Interrupt requests
  output logic        stat_req,
  output logic        vblank_req
);

  ppu_req_t   req;
  logic [7:0] vram_rdata;
  logic [7:0] oam_rdata;
  logic [7:0] regs_rdata;
  logic [7:0] ly;
  ppu_mode_t  mode;
  logic       lcd_on;
  stat_en_t   stat_en;
  logic       coincidence;

  axil_bridge axil_bridge_i (
    .clk, .reset,
    .awvalid, .awaddr, .awready, .wvalid, .wdata, .wstrb, .wready,
    .bvalid, .bresp, .bready,
    .arvalid, .araddr, .arready, .rvalid, .rdata, .rresp, .rready,
    .req, .vram_rdata, .oam_rdata, .regs_rdata
  );

  // Video RAM locked in mode 3
  video_mem #(.DEPTH(VRAM_DEPTH), .BLOCK_IN_MODE3(1'b1)) vram_i (
    .clk, .req, .mode, .rdata(vram_rdata)
  );

  // Sprite memory always open
  video_mem #(.DEPTH(OAM_DEPTH), .BLOCK_IN_MODE3(1'b0)) oam_i (
    .clk, .req, .mode, .rdata(oam_rdata)
  );

  // Line strobe waits for a pixel fetcher
  lcd_timing lcd_timing_i (
    .clk, .reset, .lcd_on, .ly, .mode, .line_end()
  );

  // LYC value only matters here through coincidence
  ppu_regs ppu_regs_i (
    .clk, .reset, .req, .ly, .mode, .rdata(regs_rdata),
    .lcd_on, .stat_en, .lyc(), .coincidence
  );

  ppu_irq ppu_irq_i (
    .clk, .reset, .ly, .mode, .stat_en, .coincidence, .stat_req, .vblank_req
  );

endmodule

/* ppu/ppu_irq.sv */
module ppu_irq
  import ppu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] ly,
  input  ppu_mode_t  mode,
  input  stat_en_t   stat_en,
  input  logic       coincidence,
  output logic       stat_req,
  output logic       vblank_req
);

  logic [7:0] ly_prev;
  ppu_mode_t  mode_prev;

  // Edge detect on line and mode
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ly_prev    <= 8'd0;
      // LCD off parks in mode 2
      mode_prev  <= PPU_MODE_2;
      stat_req   <= 1'b0;
      vblank_req <= 1'b0;
    end else begin
      ly_prev    <= ly;
      mode_prev  <= mode;
      // Entry into the first VBlank line
      vblank_req <= (ly == SCREEN_HEIGHT) && (ly_prev != SCREEN_HEIGHT);
      // LYC match first
      if (stat_en.lyc && coincidence && (ly != ly_prev)) begin
        stat_req <= 1'b1;
      end else if (mode != mode_prev) begin
        stat_req <= (stat_en.mode2 && mode == PPU_MODE_2) ||
                    (stat_en.mode1 && mode == PPU_MODE_1) ||
                    (stat_en.mode0 && mode == PPU_MODE_0);
      end else begin
        stat_req <= 1'b0;
      end
    end
  end

endmodule

/* ppu/ppu_regs.sv */
module ppu_regs
  import ppu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  ppu_req_t   req,
  input  logic [7:0] ly,
  input  ppu_mode_t  mode,
  output logic [7:0] rdata,
  output logic       lcd_on,
  output stat_en_t   stat_en,
  output logic [7:0] lyc,
  output logic       coincidence
);

  // Control registers
  logic [7:0] lcdc;
  // Stored for readback only
  logic [7:0] scy;
  logic [7:0] scx;
  logic [7:0] bgp;
  logic [7:0] wy;
  logic [7:0] wx;

  logic sel;
  logic wr;

  assign sel = (req.region == REGION_REGS);
  assign wr  = sel && req.write;

  // ==========================================================================
  // Writes
  // ==========================================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc    <= 8'h00;
      stat_en <= '0;
      lyc     <= 8'h00;
    end else if (wr) begin
      case (req.addr)
        ADDR_LCDC: lcdc <= req.wdata;
        // Only the enable bits are writable
        ADDR_STAT: stat_en <= stat_en_t'(req.wdata[6:3]);
        ADDR_LYC:  lyc <= req.wdata;
        default:   ;
      endcase
    end
  end

  // Scroll, palette and window
  always_ff @(posedge clk) begin
    if (wr) begin
      case (req.addr)
        ADDR_SCY: scy <= req.wdata;
        ADDR_SCX: scx <= req.wdata;
        ADDR_BGP: bgp <= req.wdata;
        ADDR_WY:  wy <= req.wdata;
        ADDR_WX:  wx <= req.wdata;
        // LY is read only
        default:  ;
      endcase
    end
  end

  assign lcd_on      = lcdc[7];
  assign coincidence = (ly == lyc);

  // ==========================================================================
  // Reads
  // ==========================================================================

  always_comb begin
    rdata = 8'hFF;
    if (sel) begin
      case (req.addr)
        ADDR_LCDC: rdata = lcdc;
        // Bit 7 always reads set
        ADDR_STAT: rdata = {1'b1, stat_en, coincidence, mode};
        ADDR_SCY:  rdata = scy;
        ADDR_SCX:  rdata = scx;
        ADDR_LY:   rdata = ly;
        ADDR_LYC:  rdata = lyc;
        ADDR_BGP:  rdata = bgp;
        ADDR_WY:   rdata = wy;
        ADDR_WX:   rdata = wx;
        default:   rdata = 8'hFF;
      endcase
    end
  end

endmodule

/* ppu/lcd_timing.sv */
module lcd_timing
  import ppu_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      lcd_on,
  output logic [7:0] ly,
  output ppu_mode_t mode,
  output logic      line_end
);

  // Dot position within the line
  logic [8:0] dot;

  // Last dot of the line
  assign line_end = lcd_on && (dot == DOTS_PER_LINE - 9'd1);

  // ==========================================================================
  // Dot and line counters
  // ==========================================================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot <= 9'd0;
      ly  <= 8'd0;
    end else if (!lcd_on) begin
      // Parked at the top of the frame
      dot <= 9'd0;
      ly  <= 8'd0;
    end else if (line_end) begin
      dot <= 9'd0;
      // Wrap after the last VBlank line
      if (ly == LINES_PER_FRAME - 8'd1) begin
        ly <= 8'd0;
      end else begin
        ly <= ly + 8'd1;
      end
    end else begin
      dot <= dot + 9'd1;
    end
  end

  // ==========================================================================
  // Mode from position
  // ==========================================================================

  always_comb begin
    if (ly >= SCREEN_HEIGHT) begin
      mode = PPU_MODE_1;
    end else if (dot < MODE2_LEN) begin
      mode = PPU_MODE_2;
    end else if (dot < MODE2_LEN + MODE3_LEN) begin
      mode = PPU_MODE_3;
    end else begin
      // Rest of the line is HBlank
      mode = PPU_MODE_0;
    end
  end

endmodule

/* source/video_mem.sv */
module video_mem
  import ppu_pkg::*;
#(
  parameter int DEPTH          = 8192,
  parameter bit BLOCK_IN_MODE3 = 1'b0
) (
  input  logic       clk,
  input  ppu_req_t   req,
  input  ppu_mode_t  mode,
  output logic [7:0] rdata
);

  // VRAM is the only memory locked out during pixel transfer
  localparam ppu_region_t REGION = BLOCK_IN_MODE3 ? REGION_VRAM : REGION_OAM;
  localparam logic [15:0] BASE   = BLOCK_IN_MODE3 ? VRAM_START : OAM_START;
  localparam int          AW     = $clog2(DEPTH);

  logic [7:0]    mem [DEPTH];
  logic [15:0]   offset;
  logic [AW-1:0] idx;
  logic          sel;
  logic          blocked;

  // Offset from region base
  assign offset  = req.addr - BASE;
  assign idx     = offset[AW-1:0];
  assign sel     = (req.region == REGION);
  assign blocked = BLOCK_IN_MODE3 && (mode == PPU_MODE_3);

  // Blocked writes vanish
  always_ff @(posedge clk) begin
    if (sel && req.write && !blocked) begin
      mem[idx] <= req.wdata;
    end
  end

  // Blocked or idle reads float high
  assign rdata = (sel && req.read && !blocked) ? mem[idx] : 8'hFF;

endmodule

/* source/axil_bridge.sv */
module axil_bridge
  import ppu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  // Write address and data channels
  input  logic        awvalid,
  input  logic [15:0] awaddr,
  output logic        awready,
  input  logic        wvalid,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output logic        wready,
  // Write response channel
  output logic        bvalid,
  output logic [1:0]  bresp,
  input  logic        bready,
  // Read address channel
  input  logic        arvalid,
  input  logic [15:0] araddr,
  output logic        arready,
  // Read data channel
  output logic        rvalid,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  input  logic        rready,
  // Internal byte path
  output ppu_req_t    req,
  input  logic [7:0]  vram_rdata,
  input  logic [7:0]  oam_rdata,
  input  logic [7:0]  regs_rdata
);

  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic        wr_start;
  logic        rd_start;
  logic        wr_acc;
  logic        rd_acc;
  logic [15:0] req_addr;
  logic [7:0]  rd_byte;

  // Address to region, DMA register excluded
  function automatic ppu_region_t decode_region(input logic [15:0] addr);
    ppu_region_t region;
    region = REGION_NONE;
    if (addr >= VRAM_START && addr <= VRAM_END) begin
      region = REGION_VRAM;
    end else if (addr >= OAM_START && addr <= OAM_END) begin
      region = REGION_OAM;
    end else if (addr >= REGS_START && addr <= REGS_END && addr != DMA_ADDR) begin
      region = REGION_REGS;
    end
    return region;
  endfunction

  // ==========================================================================
  // Handshakes
  // ==========================================================================

  // Write wins when both would start together
  assign wr_start = awvalid & wvalid & ~awready & ~bvalid;
  assign rd_start = arvalid & ~arready & ~rvalid & ~wr_start;

  assign wr_acc = awvalid & awready & wvalid & wready;
  assign rd_acc = arvalid & arready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      arready <= 1'b0;
      bvalid  <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      // One-cycle ready pulses
      awready <= wr_start;
      wready  <= wr_start;
      arready <= rd_start;
      // Responses hold until taken
      if (wr_acc) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_acc) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  assign bresp = RESP_OKAY;
  assign rresp = RESP_OKAY;

  // ==========================================================================
  // Request and read data
  // ==========================================================================

  assign req_addr = wr_acc ? awaddr : araddr;

  always_comb begin
    req.write  = wr_acc & wstrb[0];
    req.read   = rd_acc;
    req.region = decode_region(req_addr);
    req.addr   = req_addr;
    req.wdata  = wdata[7:0];
  end

  // Open bus for unmapped space
  always_comb begin
    case (req.region)
      REGION_VRAM: rd_byte = vram_rdata;
      REGION_OAM:  rd_byte = oam_rdata;
      REGION_REGS: rd_byte = regs_rdata;
      default:     rd_byte = 8'hFF;
    endcase
  end

  // Byte lands in lane 0
  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rdata <= {24'h0, rd_byte};
    end
  end

endmodule

/* common/ppu_pkg.sv */
package ppu_pkg;

  // ==========================================================================
  // Address map
  // ==========================================================================

  // Video RAM window
  localparam logic [15:0] VRAM_START = 16'h8000;
  localparam logic [15:0] VRAM_END   = 16'h9FFF;

  // Sprite attribute memory
  localparam logic [15:0] OAM_START  = 16'hFE00;
  localparam logic [15:0] OAM_END    = 16'hFE9F;

  // LCD register block
  localparam logic [15:0] REGS_START = 16'hFF40;
  localparam logic [15:0] REGS_END   = 16'hFF4B;

  // OAM DMA trigger lives inside the register block
  localparam logic [15:0] DMA_ADDR   = 16'hFF46;

  // Individual LCD registers
  localparam logic [15:0] ADDR_LCDC  = 16'hFF40;
  localparam logic [15:0] ADDR_STAT  = 16'hFF41;
  localparam logic [15:0] ADDR_SCY   = 16'hFF42;
  localparam logic [15:0] ADDR_SCX   = 16'hFF43;
  localparam logic [15:0] ADDR_LY    = 16'hFF44;
  localparam logic [15:0] ADDR_LYC   = 16'hFF45;
  localparam logic [15:0] ADDR_BGP   = 16'hFF47;
  localparam logic [15:0] ADDR_WY    = 16'hFF4A;
  localparam logic [15:0] ADDR_WX    = 16'hFF4B;

  // ==========================================================================
  // Frame timing
  // ==========================================================================

  localparam logic [8:0] DOTS_PER_LINE   = 9'd456;
  localparam logic [7:0] LINES_PER_FRAME = 8'd154;
  // First VBlank line
  localparam logic [7:0] SCREEN_HEIGHT   = 8'd144;
  // OAM scan and pixel transfer lengths in dots
  localparam logic [8:0] MODE2_LEN       = 9'd80;
  localparam logic [8:0] MODE3_LEN       = 9'd172;

  // ==========================================================================
  // Types
  // ==========================================================================

  // Encoding matches the STAT mode field
  typedef enum logic [1:0] {
    PPU_MODE_0 = 2'd0,  // HBlank
    PPU_MODE_1 = 2'd1,  // VBlank
    PPU_MODE_2 = 2'd2,  // OAM scan
    PPU_MODE_3 = 2'd3   // Pixel transfer
  } ppu_mode_t;

  // Target of a CPU access
  typedef enum logic [1:0] {
    REGION_NONE = 2'd0,
    REGION_VRAM = 2'd1,
    REGION_OAM  = 2'd2,
    REGION_REGS = 2'd3
  } ppu_region_t;

  // Byte request from the bus bridge
  typedef struct packed {
    logic        write;
    logic        read;
    ppu_region_t region;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } ppu_req_t;

  // STAT bits 6 down to 3
  typedef struct packed {
    logic lyc;
    logic mode2;
    logic mode1;
    logic mode0;
  } stat_en_t;

endpackage
